//--- csiRxPkg.sv
// Lane and word types, packet header union and struct, short packet limit, header ECC function
package csiRxPkg;

	// ----------------------------------------
	// Lane and word types
	// ----------------------------------------
	typedef logic [7:0]  tLaneByte;		// One HS byte per lane per clock
	typedef logic [15:0] tMergedWord;	// Lane 0 low byte, lane 1 high byte
	typedef logic [5:0]  tDataType;
	typedef logic [1:0]  tVirtChan;

	// ----------------------------------------
	// Packet header
	// ----------------------------------------
	// Same 16 bits, read by data type
	typedef union packed
	{
		logic [15:0] wordCnt;		// Long packet payload bytes
		logic [15:0] shortData;		// Frame or line number
	} tHdrField;

	// Byte 0 in the low bits, as it arrives on the lanes
	typedef struct packed
	{
		logic [7:0] ecc;			// [5:0] ECC, [7:6] reserved
		tHdrField   field;
		tVirtChan   vc;
		tDataType   dt;
	} tPktHeader;

	localparam tDataType cShortPktMaxDt = 6'h0F;	// FS/FE/LS/LE and generic short

	// CSI-2 header ECC, six parity equations over DI and WC
	function automatic logic [5:0] ecc6(input logic [23:0] d);
		logic [5:0] p;
		p[0] = ^(d & 24'hF12CB7);
		p[1] = ^(d & 24'hF2555B);
		p[2] = ^(d & 24'h749A6D);
		p[3] = ^(d & 24'hB8E38E);
		p[4] = ^(d & 24'hDF03F0);
		p[5] = ^(d & 24'hEFFC00);
		return p;
	endfunction

endpackage

//--- csiLaneMerge.sv
// Two-lane HS input register, lane 1 skew alignment, 16-bit word merge and burst end pulse
module csiLaneMerge
	import csiRxPkg::*;
(
	input  logic       iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic       inSRST,
	input  logic       iValid0,
	input  logic       iValid1,
	input  logic       iSync0,
	input  logic       iSync1,
	input  tLaneByte   iData0,
	input  tLaneByte   iData1,
	output logic       oWordVld,
	output logic       oPktEnd,
	output tMergedWord oWord
);

	// ----------------------------------------
	// Input stage
	// ----------------------------------------
	logic     rValid0;
	logic     rValid1;
	logic     rSync0;
	logic     rSync1;
	logic     rValid0Dly;		// Lane 0 valid, one extra clock
	logic     rSkew;			// Lane 1 synced one clock late
	logic     rWordVldDly;
	tLaneByte rData0;
	tLaneByte rData1;
	tLaneByte rData0Dly;		// Lane 0 byte for the skewed case
	logic     wSkew;
	logic     wWordVld;

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS or negedge inSRST)
	begin
		if (!inSRST)
		begin
			rValid0     <= 1'b0;
			rValid1     <= 1'b0;
			rSync0      <= 1'b0;
			rSync1      <= 1'b0;
			rValid0Dly  <= 1'b0;
			rSkew       <= 1'b0;
			rWordVldDly <= 1'b0;
		end
		else
		begin
			rValid0     <= iValid0;
			rValid1     <= iValid1;
			rSync0      <= iSync0;
			rSync1      <= iSync1;
			rValid0Dly  <= rValid0;
			rWordVldDly <= wWordVld;
			if (rSync0)
				rSkew <= ~rSync1;	// Held for the rest of the burst
		end
	end

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		rData0    <= iData0;
		rData1    <= iData1;
		rData0Dly <= rData0;
	end

	// ----------------------------------------
	// Merge
	// ----------------------------------------
	// Skew decided in the lane 0 sync cycle itself
	assign wSkew    = rSync0 ? ~rSync1 : rSkew;
	assign wWordVld = wSkew ? (rValid0Dly & rValid1) : (rValid0 & rValid1);
	assign oWordVld = wWordVld;
	assign oWord    = wSkew ? {rData1, rData0Dly} : {rData1, rData0};
	assign oPktEnd  = rWordVldDly & ~wWordVld;	// Falling edge of merged valid

endmodule

//--- csiPacketDecoder.sv
// Packet header capture, ECC check, long/short decode, payload forward and footer discard
module csiPacketDecoder
	import csiRxPkg::*;
(
	input  logic       iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic       inSRST,
	input  logic       iWordVld,
	input  logic       iPktEnd,
	input  tMergedWord iWord,
	output logic       oHdrVld,
	output logic       oHdrEccErr,
	output tDataType   oHsDatatype,
	output tVirtChan   oHsVc,
	output tHdrField   oHsWordCnt,		// Word count or short packet data
	output logic [7:0] oHsEcc,
	output logic       oPixWe,
	output tMergedWord oPixWd
);

	typedef enum logic [1:0] {sHeader, sPayload, sDiscard} tDecState;

	tDecState    rState;
	logic        rHalf;			// First header word held
	tMergedWord  rLowWord;		// DI and WC low byte
	logic [14:0] rPayCnt;		// Payload words left
	tPktHeader   wHdr;
	logic        wEccErr;
	logic        wLong;
	logic        wHdrDone;
	logic        wPayWr;

	// ----------------------------------------
	// Header decode
	// ----------------------------------------
	assign wHdr     = {iWord, rLowWord};
	assign wEccErr  = ecc6(wHdr[23:0]) != wHdr.ecc[5:0];	// Reserved bits ignored
	assign wLong    = wHdr.dt > cShortPktMaxDt;
	assign wHdrDone = (rState == sHeader) & rHalf & iWordVld;
	assign wPayWr   = (rState == sPayload) & iWordVld;

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS or negedge inSRST)
	begin
		if (!inSRST)
		begin
			rState  <= sHeader;
			rHalf   <= 1'b0;
			rPayCnt <= '0;
			oHdrVld <= 1'b0;
			oPixWe  <= 1'b0;
		end
		else
		begin
			oHdrVld <= wHdrDone;
			oPixWe  <= wPayWr;
			if (iPktEnd)
			begin
				rState <= sHeader;		// Every burst restarts at a header
				rHalf  <= 1'b0;
			end
			else
			begin
				case (rState)
					sHeader:
						if (iWordVld)
						begin
							rHalf <= ~rHalf;
							if (rHalf)
							begin
								// Short packet or bad ECC carries nothing forward
								if (wLong & ~wEccErr & (wHdr.field.wordCnt[15:1] != '0))
								begin
									rState  <= sPayload;
									rPayCnt <= wHdr.field.wordCnt[15:1];
								end
								else
									rState <= sDiscard;
							end
						end
					sPayload:
						if (iWordVld)
						begin
							rPayCnt <= rPayCnt - 1'b1;
							if (rPayCnt == 15'd1)
								rState <= sDiscard;	// Footer and padding follow
						end
					default: ;					// Discard until burst end
				endcase
			end
		end
	end

	// ----------------------------------------
	// Header and pixel data registers
	// ----------------------------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (!rHalf && iWordVld && rState == sHeader)
			rLowWord <= iWord;
		if (wHdrDone)
		begin
			oHsDatatype <= wHdr.dt;
			oHsVc       <= wHdr.vc;
			oHsWordCnt  <= wHdr.field;	// Held until next header
			oHsEcc      <= wHdr.ecc;
			oHdrEccErr  <= wEccErr;
		end
		if (wPayWr)
			oPixWd <= iWord;
	end

endmodule

//--- csiPixelFifo.sv
// Synchronous pixel FIFO with occupancy count, full flag and sticky drop flag
module csiPixelFifo
	import csiRxPkg::*;
#(
	parameter int pFifoDepth = 256
)
(
	input  logic       iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic       inSRST,
	input  logic       iWe,
	input  tMergedWord iWd,
	input  logic       iRe,
	output tMergedWord oRd,
	output logic       oEmpty,
	output logic       oFull,
	output logic       oDrop
);

	localparam int cAddrW = $clog2(pFifoDepth);
	localparam int cCntW  = $clog2(pFifoDepth + 1);

	tMergedWord        rMem [pFifoDepth];
	logic [cAddrW-1:0] rWrPtr;
	logic [cAddrW-1:0] rRdPtr;
	logic [cCntW-1:0]  rCount;		// Words held
	logic              wWr;
	logic              wRd;

	assign oFull  = rCount == cCntW'(pFifoDepth);
	assign oEmpty = rCount == '0;
	assign wWr    = iWe & ~oFull;	// Write refused when full
	assign wRd    = iRe & ~oEmpty;
	assign oRd    = rMem[rRdPtr];	// Head word, visible the clock after its write

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (wWr)
			rMem[rWrPtr] <= iWd;
	end

	// ----------------------------------------
	// Pointers, count, drop flag
	// ----------------------------------------
	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS or negedge inSRST)
	begin
		if (!inSRST)
		begin
			rWrPtr <= '0;
			rRdPtr <= '0;
			rCount <= '0;
			oDrop  <= 1'b0;
		end
		else
		begin
			if (wWr)
				rWrPtr <= (rWrPtr == cAddrW'(pFifoDepth - 1)) ? '0 : rWrPtr + 1'b1;
			if (wRd)
				rRdPtr <= (rRdPtr == cAddrW'(pFifoDepth - 1)) ? '0 : rRdPtr + 1'b1;
			case ({wWr, wRd})
				2'b10:   rCount <= rCount + 1'b1;
				2'b01:   rCount <= rCount - 1'b1;
				default: ;
			endcase
			if (iWe && oFull)
				oDrop <= 1'b1;			// Sticky until reset
		end
	end

endmodule

//--- csiVideoCreditOut.sv
// Sink credit counter, FIFO read request and registered video output stage
module csiVideoCreditOut
	import csiRxPkg::*;
#(
	parameter int pCreditMax = 8
)
(
	input  logic       iMipiDphyRx1_WORD_CLKOUT_HS,
	input  logic       inSRST,
	input  logic       iCredit,
	input  logic       iEmpty,
	input  tMergedWord iRd,
	output logic       oRe,
	output tMergedWord oVideoPixel,
	output logic       oVideoVd
);

	localparam int cCntW = $clog2(pCreditMax + 1);

	logic [cCntW-1:0] rCredit;		// Credits held, never above pCreditMax
	logic             wRe;

	assign wRe = (rCredit != '0) & ~iEmpty;	// Spend one credit per word
	assign oRe = wRe;

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS or negedge inSRST)
	begin
		if (!inSRST)
		begin
			rCredit  <= '0;
			oVideoVd <= 1'b0;
		end
		else
		begin
			oVideoVd <= wRe;
			case ({iCredit, wRe})
				2'b10:   rCredit <= rCredit + 1'b1;
				2'b01:   rCredit <= rCredit - 1'b1;
				default: ;				// Grant and spend cancel
			endcase
		end
	end

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
	begin
		if (wRe)
			oVideoPixel <= iRd;
	end

endmodule

//--- csiRxController.sv
// CSI-2 two-lane receive top: lane merge, packet decoder, pixel FIFO and credit output stage
module csiRxController
	import csiRxPkg::*;
#(
	parameter int pFifoDepth = 256,
	parameter int pCreditMax = 8
)
(
	input  logic       iMipiDphyRx1_WORD_CLKOUT_HS,	// HS byte clock
	input  logic       inSRST,
	// D-PHY HS lanes
	input  logic       iMipiDphyRx1_RX_VALID_HS_LAN0,
	input  logic       iMipiDphyRx1_RX_VALID_HS_LAN1,
	input  logic       iMipiDphyRx1_RX_SYNC_HS_LAN0,
	input  logic       iMipiDphyRx1_RX_SYNC_HS_LAN1,
	input  tLaneByte   iMipiDphyRx1_RX_DATA_HS_LAN0,
	input  tLaneByte   iMipiDphyRx1_RX_DATA_HS_LAN1,
	// Header report
	output logic       oHdrVld,
	output logic       oHdrEccErr,
	output tDataType   oHsDatatype,
	output tVirtChan   oHsVc,
	output tHdrField   oHsWordCnt,
	output logic [7:0] oHsEcc,
	// Video sink
	output tMergedWord oVideoPixel,
	output logic       oVideoVd,
	input  logic       iVideoCredit,
	// Flow status
	output logic       oFifoFull,
	output logic       oPixDrop
);

	logic       wWordVld;
	logic       wPktEnd;
	tMergedWord wWord;
	logic       wPixWe;
	tMergedWord wPixWd;
	logic       wFifoRe;
	logic       wFifoEmpty;
	tMergedWord wFifoRd;

	// ----------------------------------------
	// Lanes to words to packets
	// ----------------------------------------
	csiLaneMerge uLaneMerge (
		.iMipiDphyRx1_WORD_CLKOUT_HS(iMipiDphyRx1_WORD_CLKOUT_HS),	.inSRST(inSRST),
		.iValid0(iMipiDphyRx1_RX_VALID_HS_LAN0),	.iValid1(iMipiDphyRx1_RX_VALID_HS_LAN1),
		.iSync0(iMipiDphyRx1_RX_SYNC_HS_LAN0),		.iSync1(iMipiDphyRx1_RX_SYNC_HS_LAN1),
		.iData0(iMipiDphyRx1_RX_DATA_HS_LAN0),		.iData1(iMipiDphyRx1_RX_DATA_HS_LAN1),
		.oWordVld(wWordVld),	.oPktEnd(wPktEnd),	.oWord(wWord)
	);

	csiPacketDecoder uPacketDecoder (
		.iMipiDphyRx1_WORD_CLKOUT_HS(iMipiDphyRx1_WORD_CLKOUT_HS),	.inSRST(inSRST),
		.iWordVld(wWordVld),	.iPktEnd(wPktEnd),	.iWord(wWord),
		.oHdrVld(oHdrVld),		.oHdrEccErr(oHdrEccErr),
		.oHsDatatype(oHsDatatype),	.oHsVc(oHsVc),
		.oHsWordCnt(oHsWordCnt),	.oHsEcc(oHsEcc),
		.oPixWe(wPixWe),		.oPixWd(wPixWd)
	);

	// ----------------------------------------
	// Pixel buffer and sink side
	// ----------------------------------------
	csiPixelFifo #(.pFifoDepth(pFifoDepth)) uPixelFifo (
		.iMipiDphyRx1_WORD_CLKOUT_HS(iMipiDphyRx1_WORD_CLKOUT_HS),	.inSRST(inSRST),
		.iWe(wPixWe),	.iWd(wPixWd),	.iRe(wFifoRe),	.oRd(wFifoRd),
		.oEmpty(wFifoEmpty),	.oFull(oFifoFull),	.oDrop(oPixDrop)
	);

	csiVideoCreditOut #(.pCreditMax(pCreditMax)) uVideoCreditOut (
		.iMipiDphyRx1_WORD_CLKOUT_HS(iMipiDphyRx1_WORD_CLKOUT_HS),	.inSRST(inSRST),
		.iCredit(iVideoCredit),	.iEmpty(wFifoEmpty),	.iRd(wFifoRd),
		.oRe(wFifoRe),	.oVideoPixel(oVideoPixel),	.oVideoVd(oVideoVd)
	);

endmodule

//--- tbCsiRx_chk.sv
// Bound assertions on the receive controller: credit use, header pulse width, quiet reset
module tbCsiRx_chk
(
	input logic iMipiDphyRx1_WORD_CLKOUT_HS,
	input logic inSRST,
	input logic iVideoCredit,
	input logic oVideoVd,
	input logic oHdrVld,
	input logic oPixDrop
);

	logic [7:0] rHeld;		// Credits granted by the sink, not yet spent

	always_ff @(posedge iMipiDphyRx1_WORD_CLKOUT_HS or negedge inSRST)
	begin
		if (!inSRST)
			rHeld <= '0;
		else
		begin
			case ({iVideoCredit, oVideoVd})
				2'b10:   rHeld <= rHeld + 8'd1;
				2'b01:   rHeld <= rHeld - 8'd1;
				default: ;		// Grant and spend in one cycle
			endcase
		end
	end

	// ----------------------------------------
	aVdNeedsCredit: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		disable iff (!inSRST) oVideoVd |-> rHeld != 8'd0)
		else $error("oVideoVd high with no unspent credit");

	aHdrVldPulse: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		disable iff (!inSRST) oHdrVld |=> !oHdrVld)
		else $error("oHdrVld high for more than one cycle");

	aQuietInReset: assert property (@(posedge iMipiDphyRx1_WORD_CLKOUT_HS)
		!inSRST |-> (!oVideoVd && !oPixDrop))
		else $error("oVideoVd or oPixDrop high during reset");

endmodule

bind csiRxController tbCsiRx_chk chk_i (
	.iMipiDphyRx1_WORD_CLKOUT_HS(iMipiDphyRx1_WORD_CLKOUT_HS),
	.inSRST(inSRST),
	.iVideoCredit(iVideoCredit),
	.oVideoVd(oVideoVd),
	.oHdrVld(oHdrVld),
	.oPixDrop(oPixDrop)
);

//--- tbCsiRx.sv
// Testbench for the CSI-2 receive controller with clock, reset, random packets, model, checks and timeout
module tbCsiRx
	import csiRxPkg::*;
();

	localparam int cFifoDepth = 256;
	localparam int cCreditMax = 8;
	localparam int cPktCount  = 60;

	logic       wordClk = 1'b0;
	logic       inSRST;
	logic       valid0;
	logic       valid1;
	logic       sync0;
	logic       sync1;
	tLaneByte   data0;
	tLaneByte   data1;
	logic       videoCredit;
	logic       hdrVld;
	logic       hdrEccErr;
	tDataType   hsDatatype;
	tVirtChan   hsVc;
	tHdrField   hsWordCnt;
	logic [7:0] hsEcc;
	tMergedWord videoPixel;
	logic       videoVd;
	logic       fifoFull;
	logic       pixDrop;

	logic [31:0] rngState;
	tMergedWord  allWords[$];		// Every word of every packet in send order
	int          pktFirst[$];
	int          pktLen[$];
	int          pktSkew[$];		// Lane 1 late by this many cycles
	int          pktGap[$];
	tPktHeader   expHdrQ[$];
	logic        expErrQ[$];
	tMergedWord  expPixQ[$];
	int          granted;
	int          vdCount;
	int          cycleCnt;
	int          cycleLimit;
	int          hdrErrors;
	int          pixErrors;
	int          flowErrors;
	int          p;

	csiRxController #(.pFifoDepth(cFifoDepth), .pCreditMax(cCreditMax)) dut_i (
		.iMipiDphyRx1_WORD_CLKOUT_HS(wordClk),	.inSRST(inSRST),
		.iMipiDphyRx1_RX_VALID_HS_LAN0(valid0),	.iMipiDphyRx1_RX_VALID_HS_LAN1(valid1),
		.iMipiDphyRx1_RX_SYNC_HS_LAN0(sync0),	.iMipiDphyRx1_RX_SYNC_HS_LAN1(sync1),
		.iMipiDphyRx1_RX_DATA_HS_LAN0(data0),	.iMipiDphyRx1_RX_DATA_HS_LAN1(data1),
		.oHdrVld(hdrVld),	.oHdrEccErr(hdrEccErr),	.oHsDatatype(hsDatatype),
		.oHsVc(hsVc),	.oHsWordCnt(hsWordCnt),	.oHsEcc(hsEcc),
		.oVideoPixel(videoPixel),	.oVideoVd(videoVd),	.iVideoCredit(videoCredit),
		.oFifoFull(fifoFull),	.oPixDrop(pixDrop)
	);

	always #50 wordClk = ~wordClk;

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic checkHeader(input tPktHeader got, input logic gotErr,
		input tPktHeader exp, input logic expErr);
		if (got !== exp || gotErr !== expErr)
		begin
			hdrErrors++;
			$display("ERR %0t: header dt %h vc %h field %h ecc %h err %b", $time,
				got.dt, got.vc, got.field.wordCnt, got.ecc, gotErr);
			$display("ERR %0t: expected dt %h vc %h field %h ecc %h err %b", $time,
				exp.dt, exp.vc, exp.field.wordCnt, exp.ecc, expErr);
		end
	endtask

	task automatic checkPixel(input tMergedWord got, input tMergedWord exp);
		if (got !== exp)
		begin
			pixErrors++;
			$display("ERR %0t: pixel %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			flowErrors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------
	// Packet generation and model
	// ----------------------------------------
	task automatic buildPackets();
		tPktHeader   hdr;
		logic [31:0] rnd;
		logic        isLong;
		logic        badEcc;
		int          wc;
		int          k;
		int          n;
		for (n = 0; n < cPktCount; n++)
		begin
			rnd    = nextRandom();
			isLong = (rnd % 4) != 0;	// Three long packets in four
			badEcc = (rnd[7:4] % 6) == 0;
			hdr    = '0;
			hdr.vc = rnd[9:8];
			wc     = 0;
			if (isLong)
			begin
				hdr.dt = tDataType'(6'h10 + nextRandom() % 48);
				wc     = 2 * (1 + int'(nextRandom() % 20));	// Even count from 2 to 40 bytes
				hdr.field.wordCnt = 16'(wc);
			end
			else
			begin
				hdr.dt = tDataType'(nextRandom() % 16);
				hdr.field.shortData = rnd[31:16];	// Frame or line number
			end
			hdr.ecc = {2'b00, ecc6(hdr[23:0])};
			if (badEcc)
				hdr.ecc = hdr.ecc ^ (8'h01 << (rnd[23:16] % 6));	// One flipped ECC bit
			expHdrQ.push_back(hdr);
			expErrQ.push_back(badEcc);
			pktFirst.push_back(allWords.size());
			pktSkew.push_back(int'(rnd[12]));
			pktGap.push_back(3 + int'(rnd[14:13]));
			allWords.push_back(hdr[15:0]);		// DI and WC low byte
			allWords.push_back(hdr[31:16]);		// WC high byte and ECC
			if (isLong)
			begin
				for (k = 0; k < wc / 2; k++)
				begin
					rnd = nextRandom();
					allWords.push_back(rnd[15:0]);
					if (!badEcc)
						expPixQ.push_back(rnd[15:0]);	// Only good headers pass payload
				end
				rnd = nextRandom();
				allWords.push_back(rnd[15:0]);	// Footer never seen at the output
			end
			pktLen.push_back(allWords.size() - pktFirst[n]);
		end
		cycleLimit = allWords.size() * 4 + 2000;
	endtask

	// ----------------------------------------
	// Lane drivers
	// ----------------------------------------
	task automatic sendPacket(input int first, input int n, input int skew);
		int i;
		for (i = 0; i < n + skew; i++)
		begin
			@(posedge wordClk);
			valid0 <= (i < n);
			sync0  <= (i == 0);		// Sync with the first byte
			data0  <= (i < n) ? allWords[first + i][7:0] : 8'h00;
			valid1 <= (i >= skew) && (i - skew < n);
			sync1  <= (i == skew);
			data1  <= ((i >= skew) && (i - skew < n)) ? allWords[first + i - skew][15:8] : 8'h00;
		end
	endtask

	task automatic idleLanes(input int n);
		repeat (n)
		begin
			@(posedge wordClk);
			valid0 <= 1'b0;
			valid1 <= 1'b0;
			sync0  <= 1'b0;
			sync1  <= 1'b0;
			data0  <= 8'h00;
			data1  <= 8'h00;
		end
	endtask

	// Sink credits withheld for 128 of every 512 cycles
	always @(posedge wordClk)
	begin
		if (!inSRST)
			videoCredit <= 1'b0;
		else if (cycleCnt % 512 < 384 && granted - vdCount < cCreditMax && nextRandom() % 8 != 0)
		begin
			videoCredit <= 1'b1;
			granted++;
		end
		else
			videoCredit <= 1'b0;
	end

	// Output monitor at mid-cycle
	always @(negedge wordClk)
	begin : monitor
		tPktHeader got;
		if (inSRST)
		begin
			if (videoVd)
				vdCount++;
			if (vdCount > granted)
			begin
				flowErrors++;
				$display("ERR %0t: %0d video words against %0d credits", $time, vdCount, granted);
			end
			if (hdrVld)
			begin
				got.dt    = hsDatatype;
				got.vc    = hsVc;
				got.field = hsWordCnt;
				got.ecc   = hsEcc;
				if (expHdrQ.size() == 0)
				begin
					flowErrors++;
					$display("Header reported at %0t when no packet was outstanding", $time);
				end
				else
					checkHeader(got, hdrEccErr, expHdrQ.pop_front(), expErrQ.pop_front());
			end
			if (videoVd)
			begin
				if (expPixQ.size() == 0)
				begin
					flowErrors++;
					$display("Extra pixel %h at %0t beyond the expected stream", videoPixel, $time);
				end
				else
					checkPixel(videoPixel, expPixQ.pop_front());
			end
			checkFlag(pixDrop, 1'b0, "oPixDrop");
			checkFlag(fifoFull, 1'b0, "oFifoFull");
		end
	end

	always @(negedge wordClk)
	begin
		cycleCnt++;
		if (cycleCnt > cycleLimit)
		begin
			$display("Timeout after %0d cycles, headers or pixels still missing", cycleCnt);
			$display("Done: errors found");
			$finish;
		end
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		inSRST      = 1'b0;
		valid0      = 1'b0;
		valid1      = 1'b0;
		sync0       = 1'b0;
		sync1       = 1'b0;
		data0       = 8'h00;
		data1       = 8'h00;
		videoCredit = 1'b0;
		granted     = 0;
		vdCount     = 0;
		cycleCnt    = 0;
		hdrErrors   = 0;
		pixErrors   = 0;
		flowErrors  = 0;
		rngState    = 32'hd4d23c9d;
		buildPackets();
		repeat (2) @(posedge wordClk);
		inSRST <= 1'b1;
		repeat (4)
		begin
			@(negedge wordClk);		// Quiet outputs before the first packet
			checkFlag(hdrVld, 1'b0, "oHdrVld after reset");
			checkFlag(videoVd, 1'b0, "oVideoVd after reset");
			checkFlag(pixDrop, 1'b0, "oPixDrop after reset");
			checkFlag(fifoFull, 1'b0, "oFifoFull after reset");
		end
		for (p = 0; p < cPktCount; p++)
		begin
			sendPacket(pktFirst[p], pktLen[p], pktSkew[p]);
			idleLanes(pktGap[p]);
		end
		while (expHdrQ.size() != 0 || expPixQ.size() != 0)
			@(negedge wordClk);
		repeat (40) @(negedge wordClk);		// Room for stray pixels
		$display("Errors: header %0d, pixel %0d, flow %0d", hdrErrors, pixErrors, flowErrors);
		if (hdrErrors + pixErrors + flowErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- project.f
csiRxPkg.sv
csiLaneMerge.sv
csiPacketDecoder.sv
csiPixelFifo.sv
csiVideoCreditOut.sv
csiRxController.sv
tbCsiRx_chk.sv
tbCsiRx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbCsiRx
FILELIST  = project.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf $(BUILDDIR) $(LOG)
